// ==== id_branch_unit.sv ====
module id_branch_unit import id_pkg::*; (
    input  logic        is_eq,
    input  logic        is_ne,
    input  logic        is_gez,
    input  logic        is_gtz,
    input  logic        is_lez,
    input  logic        is_ltz,
    input  logic        is_jump_imm,
    input  logic        is_jump_reg,
    input  word_t       pc_next,     // delay slot pc, already pc + 4
    input  logic [15:0] imm,
    input  logic [25:0] jidx,
    input  word_t       rs_value,
    input  word_t       rt_value,
    input  logic        load_stall,
    output br_t         br
);
    logic  rs_eq_rt;
    logic  rs_zero;
    logic  rs_neg;
    logic  cond_branch;
    logic  taken;
    word_t br_offset;

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_zero  = (rs_value == '0);
    assign rs_neg   = rs_value[$bits(word_t)-1];

    assign cond_branch = is_eq | is_ne | is_gez | is_gtz | is_lez | is_ltz;

    assign taken = (is_eq & rs_eq_rt)
                 | (is_ne & ~rs_eq_rt)
                 | (is_gez & ~rs_neg)
                 | (is_gtz & ~rs_neg & ~rs_zero)
                 | (is_lez & (rs_neg | rs_zero))
                 | (is_ltz & rs_neg)
                 | is_jump_imm
                 | is_jump_reg;

    assign br_offset = {{($bits(word_t) - 18){imm[15]}}, imm, 2'b00};

    always_comb begin
        br.is_branch = cond_branch | is_jump_imm | is_jump_reg;
        br.br_taken  = taken;
        br.br_stall  = load_stall & taken;   // operands not ready yet
        if (cond_branch)
            br.br_target = pc_next + br_offset;
        else if (is_jump_reg)
            br.br_target = rs_value;
        else
            br.br_target = {pc_next[31:28], jidx, 2'b00};   // j, jal region jump
    end

endmodule

// ==== id_decode.sv ====
`include "id_stage_cfg.svh"

module id_decode import id_pkg::*; (
    input  word_t     inst,
    input  logic      fs_ex,
    input  exc_code_t fs_exc_code,
    input  logic      bd,
    output ds_ctrl_t  ctrl,
    output reg_addr_t rs,
    output reg_addr_t rt,
    output logic      no_rt_read,
    output logic      is_eq,
    output logic      is_ne,
    output logic      is_gez,
    output logic      is_gtz,
    output logic      is_lez,
    output logic      is_ltz,
    output logic      is_jump_imm,
    output logic      is_jump_reg
);
    logic [5:0] op;
    logic [5:0] func;
    reg_addr_t  rd;
    logic [4:0] sa;
    logic       special;
    logic       regimm;
    logic       inst_addu, inst_subu, inst_add, inst_sub, inst_slt, inst_sltu;
    logic       inst_and, inst_or, inst_xor, inst_nor, inst_sll, inst_srl, inst_sra;
    logic       inst_addiu, inst_addi, inst_slti, inst_sltiu;
    logic       inst_andi, inst_ori, inst_xori, inst_lui, inst_lw, inst_sw;
    logic       inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic       inst_bgezal, inst_bltzal, inst_j, inst_jal, inst_jr, inst_jalr;
    logic       inst_syscall, inst_break;
    logic       inst_defined;
    logic       dst_is_link;
    logic       dst_is_rt;
    logic       no_dest;

    assign op      = inst[31:26];
    assign rs      = inst[25:21];
    assign rt      = inst[20:16];
    assign rd      = inst[15:11];
    assign sa      = inst[10:6];
    assign func    = inst[5:0];
    assign special = (op == 6'h00);
    assign regimm  = (op == 6'h01);

    // r-type alu
    assign inst_addu = special && func == 6'h21 && sa == 5'd0;
    assign inst_add  = special && func == 6'h20 && sa == 5'd0;
    assign inst_subu = special && func == 6'h23 && sa == 5'd0;
    assign inst_sub  = special && func == 6'h22 && sa == 5'd0;
    assign inst_slt  = special && func == 6'h2a && sa == 5'd0;
    assign inst_sltu = special && func == 6'h2b && sa == 5'd0;
    assign inst_and  = special && func == 6'h24 && sa == 5'd0;
    assign inst_or   = special && func == 6'h25 && sa == 5'd0;
    assign inst_xor  = special && func == 6'h26 && sa == 5'd0;
    assign inst_nor  = special && func == 6'h27 && sa == 5'd0;
    assign inst_sll  = special && func == 6'h00 && rs == 5'd0;
    assign inst_srl  = special && func == 6'h02 && rs == 5'd0;
    assign inst_sra  = special && func == 6'h03 && rs == 5'd0;
    assign inst_jr   = special && func == 6'h08 && rt == 5'd0 && rd == 5'd0 && sa == 5'd0;
    assign inst_jalr = special && func == 6'h09 && rt == 5'd0 && sa == 5'd0;
    assign inst_syscall = special && func == 6'h0c;
    assign inst_break   = special && func == 6'h0d;

    // immediates and memory
    assign inst_addi  = (op == 6'h08);
    assign inst_addiu = (op == 6'h09);
    assign inst_slti  = (op == 6'h0a);
    assign inst_sltiu = (op == 6'h0b);
    assign inst_andi  = (op == 6'h0c);
    assign inst_ori   = (op == 6'h0d);
    assign inst_xori  = (op == 6'h0e);
    assign inst_lui   = (op == 6'h0f) && rs == 5'd0;
    assign inst_lw    = (op == 6'h23);
    assign inst_sw    = (op == 6'h2b);

    // branches and jumps, regimm picks the kind through rt
    assign inst_beq    = (op == 6'h04);
    assign inst_bne    = (op == 6'h05);
    assign inst_blez   = (op == 6'h06) && rt == 5'd0;
    assign inst_bgtz   = (op == 6'h07) && rt == 5'd0;
    assign inst_bltz   = regimm && rt == 5'h00;
    assign inst_bgez   = regimm && rt == 5'h01;
    assign inst_bltzal = regimm && rt == 5'h10;
    assign inst_bgezal = regimm && rt == 5'h11;
    assign inst_j      = (op == 6'h02);
    assign inst_jal    = (op == 6'h03);

    assign inst_defined = inst_addu | inst_subu | inst_add | inst_sub | inst_slt | inst_sltu
                        | inst_and | inst_or | inst_xor | inst_nor | inst_sll | inst_srl
                        | inst_sra | inst_addiu | inst_addi | inst_slti | inst_sltiu
                        | inst_andi | inst_ori | inst_xori | inst_lui | inst_lw | inst_sw
                        | inst_beq | inst_bne | inst_bgez | inst_bgtz | inst_blez | inst_bltz
                        | inst_bgezal | inst_bltzal | inst_j | inst_jal | inst_jr | inst_jalr
                        | inst_syscall | inst_break;

    assign is_eq       = inst_beq;
    assign is_ne       = inst_bne;
    assign is_gez      = inst_bgez | inst_bgezal;
    assign is_gtz      = inst_bgtz;
    assign is_lez      = inst_blez;
    assign is_ltz      = inst_bltz | inst_bltzal;
    assign is_jump_imm = inst_j | inst_jal;
    assign is_jump_reg = inst_jr | inst_jalr;

    assign dst_is_link = inst_jal | inst_bgezal | inst_bltzal;
    assign dst_is_rt   = inst_addiu | inst_addi | inst_slti | inst_sltiu | inst_andi
                       | inst_ori | inst_xori | inst_lui | inst_lw;
    assign no_dest     = inst_sw | inst_beq | inst_bne | inst_bgez | inst_bgtz | inst_blez
                       | inst_bltz | inst_j | inst_jr | inst_syscall | inst_break;
    // rt field is an immediate dest, a regimm code or jump index bits
    assign no_rt_read  = dst_is_rt | regimm | inst_bgtz | inst_blez | inst_j | inst_jal;

    always_comb begin
        ctrl.alu_op[0]  = inst_addu | inst_add | inst_addiu | inst_addi | inst_lw | inst_sw
                        | inst_jal | inst_jalr | inst_bgezal | inst_bltzal; // addresses, links
        ctrl.alu_op[1]  = inst_subu | inst_sub;
        ctrl.alu_op[2]  = inst_slt | inst_slti;
        ctrl.alu_op[3]  = inst_sltu | inst_sltiu;
        ctrl.alu_op[4]  = inst_and | inst_andi;
        ctrl.alu_op[5]  = inst_nor;
        ctrl.alu_op[6]  = inst_or | inst_ori;
        ctrl.alu_op[7]  = inst_xor | inst_xori;
        ctrl.alu_op[8]  = inst_sll;
        ctrl.alu_op[9]  = inst_srl;
        ctrl.alu_op[10] = inst_sra;
        ctrl.alu_op[11] = inst_lui;

        ctrl.load_op    = inst_lw;
        ctrl.src1_is_sa = inst_sll | inst_srl | inst_sra;
        ctrl.src1_is_pc = dst_is_link | inst_jalr;
        ctrl.src2_is_8  = dst_is_link | inst_jalr;   // link value is pc + 8
        if (inst_andi | inst_ori | inst_xori | inst_lui)
            ctrl.imm_sel = IMM_SEL_ZEXT;
        else if (inst_addiu | inst_addi | inst_slti | inst_sltiu | inst_lw | inst_sw)
            ctrl.imm_sel = IMM_SEL_SEXT;
        else
            ctrl.imm_sel = IMM_SEL_REG;

        if (dst_is_link)
            ctrl.dest = reg_addr_t'(`ID_LINK_REG);
        else if (dst_is_rt)
            ctrl.dest = rt;
        else if (no_dest)
            ctrl.dest = '0;
        else
            ctrl.dest = rd;

        ctrl.gr_we  = inst_defined & ~no_dest;
        ctrl.mem_we = inst_sw;
        ctrl.imm    = inst[15:0];

        ctrl.ex = fs_ex | ~inst_defined | inst_syscall | inst_break;
        if (!inst_defined)
            ctrl.exc_code = exc_code_t'(`ID_EXC_RI);
        else if (inst_syscall)
            ctrl.exc_code = exc_code_t'(`ID_EXC_SYS);
        else if (inst_break)
            ctrl.exc_code = exc_code_t'(`ID_EXC_BP);
        else
            ctrl.exc_code = fs_exc_code;
        ctrl.bd = bd;
    end

endmodule

// ==== id_operand_fwd.sv ====
module id_operand_fwd import id_pkg::*; (
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  logic      no_rt_read,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    input  fwd_src_t  exe_fwd,
    input  fwd_src_t  mem_fwd,
    input  fwd_src_t  wb_fwd,
    input  logic      es_load_op,
    output word_t     rs_value,
    output word_t     rt_value,
    output logic      load_stall
);
    logic rs_hit_exe, rs_hit_mem, rs_hit_wb;
    logic rt_hit_exe, rt_hit_mem, rt_hit_wb;
    logic rt_used;

    assign rt_used = ~no_rt_read && rt != '0;

    // r0 never forwards, so a dest of 0 means nothing to take
    assign rs_hit_exe = rs != '0 && rs == exe_fwd.dest;
    assign rs_hit_mem = rs != '0 && rs == mem_fwd.dest;
    assign rs_hit_wb  = rs != '0 && rs == wb_fwd.dest;
    assign rt_hit_exe = rt_used && rt == exe_fwd.dest;
    assign rt_hit_mem = rt_used && rt == mem_fwd.dest;
    assign rt_hit_wb  = rt_used && rt == wb_fwd.dest;

    // youngest producer wins
    always_comb begin
        if (rs_hit_exe)
            rs_value = exe_fwd.result;
        else if (rs_hit_mem)
            rs_value = mem_fwd.result;
        else if (rs_hit_wb)
            rs_value = wb_fwd.result;   // also covers the rf write in flight
        else
            rs_value = rf_rdata1;
    end

    always_comb begin
        if (rt_hit_exe)
            rt_value = exe_fwd.result;
        else if (rt_hit_mem)
            rt_value = mem_fwd.result;
        else if (rt_hit_wb)
            rt_value = wb_fwd.result;
        else
            rt_value = rf_rdata2;
    end

    // load data only exists after mem, exe result is just the address
    assign load_stall = es_load_op & (rs_hit_exe | rt_hit_exe);

endmodule

// ==== id_pkg.sv ====
`include "id_stage_cfg.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0]   word_t;
    typedef logic [`ID_REG_AW-1:0] reg_addr_t;
    typedef logic [`ID_EXC_W-1:0]  exc_code_t;

    // one-hot, bit 0 upward: add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [11:0] alu_op_t;

    // source 2 select
    typedef logic [1:0] imm_sel_t;
    localparam imm_sel_t IMM_SEL_REG  = 2'b00;
    localparam imm_sel_t IMM_SEL_ZEXT = 2'b01;
    localparam imm_sel_t IMM_SEL_SEXT = 2'b10;

    typedef struct packed {
        logic      ex;        // fetch already raised an exception
        exc_code_t exc_code;
        logic      bd;        // instruction sits in a delay slot
        word_t     inst;
        word_t     pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_write_t;

    // dest of 0 means the stage has nothing to forward
    typedef struct packed {
        reg_addr_t dest;
        word_t     result;
    } fwd_src_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        load_op;
        logic        src1_is_sa;
        logic        src1_is_pc;
        imm_sel_t    imm_sel;
        logic        src2_is_8;
        logic        gr_we;
        logic        mem_we;
        reg_addr_t   dest;
        logic [15:0] imm;
        logic        ex;
        exc_code_t   exc_code;
        logic        bd;
    } ds_ctrl_t;

    typedef struct packed {
        ds_ctrl_t ctrl;
        word_t    rs_value;
        word_t    rt_value;
        word_t    pc;
    } ds_to_es_t;

    typedef struct packed {
        logic  is_branch;
        logic  br_stall;   // taken, but rs/rt still waiting on a load
        logic  br_taken;
        word_t br_target;
    } br_t;

endpackage

// ==== id_regfile.sv ====
`include "id_stage_cfg.svh"

module id_regfile import id_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  wb_write_t wr,
    output word_t     rdata1,
    output word_t     rdata2
);
    word_t regs [`ID_NUM_REGS];

    // write lands on the edge, same-cycle reads see the old value
    always_ff @(posedge clk) begin
        if (wr.we) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 is hardwired to zero whatever was written there
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== id_stage.f ====
+incdir+.
id_pkg.sv
id_decode.sv
id_regfile.sv
id_operand_fwd.sv
id_branch_unit.sv
id_stage.sv
tb_id_stage.sv

// ==== id_stage.sv ====
module id_stage import id_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      es_allowin,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds_bus,
    input  wb_write_t ws_to_rf,
    input  fwd_src_t  exe_fwd,
    input  fwd_src_t  mem_fwd,
    input  fwd_src_t  wb_fwd,
    input  logic      es_load_op,
    output logic      ds_allowin,
    output logic      ds_to_es_valid,
    output ds_to_es_t ds_to_es_bus,
    output br_t       br_bus
);
    logic      ds_valid;
    logic      ds_ready_go;
    fs_to_ds_t ds_r;        // the decode pipeline register
    ds_ctrl_t  ctrl;
    reg_addr_t rs;
    reg_addr_t rt;
    logic      no_rt_read;
    logic      is_eq, is_ne, is_gez, is_gtz, is_lez, is_ltz;
    logic      is_jump_imm, is_jump_reg;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     rs_value;
    word_t     rt_value;
    logic      load_stall;

    assign ds_ready_go    = ~load_stall;
    assign ds_allowin     = ~ds_valid | (ds_ready_go & es_allowin);
    assign ds_to_es_valid = ds_valid & ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_r <= '0;   // flush wins over a transfer in the same cycle
        end else if (fs_to_ds_valid && ds_allowin) begin
            ds_r <= fs_to_ds_bus;
        end
    end

    id_decode u_decode (
        .inst        (ds_r.inst),
        .fs_ex       (ds_r.ex),
        .fs_exc_code (ds_r.exc_code),
        .bd          (ds_r.bd),
        .ctrl        (ctrl),
        .rs          (rs),
        .rt          (rt),
        .no_rt_read  (no_rt_read),
        .is_eq       (is_eq),
        .is_ne       (is_ne),
        .is_gez      (is_gez),
        .is_gtz      (is_gtz),
        .is_lez      (is_lez),
        .is_ltz      (is_ltz),
        .is_jump_imm (is_jump_imm),
        .is_jump_reg (is_jump_reg)
    );

    id_regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .wr     (ws_to_rf),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    id_operand_fwd u_operand_fwd (
        .rs         (rs),
        .rt         (rt),
        .no_rt_read (no_rt_read),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .exe_fwd    (exe_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .es_load_op (es_load_op),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall)
    );

    // pc_next is the delay slot pc taken off the live fetch bus
    id_branch_unit u_branch_unit (
        .is_eq       (is_eq),
        .is_ne       (is_ne),
        .is_gez      (is_gez),
        .is_gtz      (is_gtz),
        .is_lez      (is_lez),
        .is_ltz      (is_ltz),
        .is_jump_imm (is_jump_imm),
        .is_jump_reg (is_jump_reg),
        .pc_next     (fs_to_ds_bus.pc),
        .imm         (ctrl.imm),
        .jidx        (ds_r.inst[25:0]),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .load_stall  (load_stall),
        .br          (br_bus)
    );

    always_comb begin
        ds_to_es_bus.ctrl     = ctrl;
        ds_to_es_bus.rs_value = rs_value;
        ds_to_es_bus.rt_value = rt_value;
        ds_to_es_bus.pc       = ds_r.pc;
    end

    // instruction matches are mutually exclusive, so at most one alu op
    a_alu_op_onehot: assert property (
        @(posedge clk) disable iff (reset)
        ds_valid |-> $onehot0(ctrl.alu_op)
    );

    // held instruction must not move while execute back-pressures
    a_hold_when_blocked: assert property (
        @(posedge clk) disable iff (reset)
        ds_valid && !ds_allowin && !flush |=> $stable(ds_r)
    );

endmodule

// ==== id_stage_cfg.svh ====
`ifndef ID_STAGE_CFG_SVH
`define ID_STAGE_CFG_SVH

// datapath and register file geometry
`define ID_XLEN      32
`define ID_REG_AW    5
`define ID_NUM_REGS  32

// jal, bgezal and bltzal write their return address here
`define ID_LINK_REG  31

// exception codes, as in the cp0 cause register
`define ID_EXC_W     5
`define ID_EXC_SYS   8   // syscall
`define ID_EXC_BP    9   // break
`define ID_EXC_RI    10  // reserved instruction

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the decode stage testbench with verilator, run it, judge from the log
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert -Mdir obj_dir --top-module tb_id_stage -f id_stage.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_id_stage > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
    exit 1
fi
if ! grep -q "SIMULATION PASSED" "$log"; then
    echo "no verdict found in $log"
    exit 1
fi
exit 0

// ==== tb_id_stage.sv ====
`include "id_stage_cfg.svh"

module tb_id_stage import id_pkg::*; ();

    localparam int NUM_ROWS = 20;
    localparam int PRELOAD  = `ID_NUM_REGS - 1;   // r1 to r31
    localparam int PERIOD   = 4;
    localparam int LIMIT    = (NUM_ROWS + PRELOAD + 20) * 4 * PERIOD;

    localparam alu_op_t ALU_NONE = 12'h000;
    localparam alu_op_t ALU_ADD  = 12'h001;
    localparam alu_op_t ALU_OR   = 12'h040;

    localparam word_t EXE_RES = 32'hee00_1234;
    localparam word_t MEM_RES = 32'hdd00_5678;
    localparam word_t WB_RES  = 32'hcc00_9abc;

    // one table row holds stimulus first and expected values after it
    typedef struct packed {
        logic      issue;        // 0 keeps the held instruction
        word_t     inst;
        word_t     pc;
        fwd_src_t  exe;
        fwd_src_t  mem;
        fwd_src_t  wb;
        logic      load_op;
        logic      allowin;
        logic      flush;
        logic      exp_valid;
        logic      exp_allowin;
        logic      only_valid;   // after a flush nothing else is meaningful
        reg_addr_t exp_dest;
        alu_op_t   exp_alu;
        imm_sel_t  exp_imm_sel;
        word_t     exp_rs;
        word_t     exp_rt;
        logic      exp_taken;
        logic      exp_branch;
        word_t     exp_target;
        logic      exp_ex;
        exc_code_t exp_code;
    } test_row_t;

    logic      clk;
    logic      reset;
    logic      flush;
    logic      es_allowin;
    logic      fs_to_ds_valid;
    logic      es_load_op;
    fs_to_ds_t fs_to_ds_bus;
    wb_write_t ws_to_rf;
    fwd_src_t  exe_fwd;
    fwd_src_t  mem_fwd;
    fwd_src_t  wb_fwd;
    logic      ds_allowin;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es_bus;
    br_t       br_bus;

    word_t     model [`ID_NUM_REGS];   // expected register file contents
    test_row_t tbl [$];
    integer    seed = 45;
    int        cur_row;
    int        row_errs;
    int        pass_count;
    int        fail_count;

    id_stage dut0 (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .es_allowin     (es_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ws_to_rf       (ws_to_rf),
        .exe_fwd        (exe_fwd),
        .mem_fwd        (mem_fwd),
        .wb_fwd         (wb_fwd),
        .es_load_op     (es_load_op),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .br_bus         (br_bus)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT);
        $display("timeout: run still busy after %0d time units", LIMIT);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic word_t rtype_inst(input reg_addr_t rs, input reg_addr_t rt,
                                         input reg_addr_t rd, input logic [5:0] func);
        return {6'h00, rs, rt, rd, 5'd0, func};
    endfunction

    function automatic word_t itype_inst(input logic [5:0] op, input reg_addr_t rs,
                                         input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jtype_inst(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic fwd_src_t fwd_from(input reg_addr_t dest, input word_t result);
        fwd_src_t f;
        f.dest   = dest;
        f.result = result;
        return f;
    endfunction

    function automatic word_t reg_val(input reg_addr_t r);
        return (r == '0) ? '0 : model[r];
    endfunction

    // conditional branches are relative to the delay slot
    function automatic word_t cond_target(input word_t pc, input logic [15:0] imm);
        return pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};
    endfunction

    function automatic word_t jump_target(input word_t pc, input logic [25:0] idx);
        word_t pc4;
        pc4 = pc + 32'd4;
        return {pc4[31:28], idx, 2'b00};
    endfunction

    task automatic preload_regs();
        word_t v;
        model[0] = '0;
        for (int r = 1; r < `ID_NUM_REGS; r++) begin
            v = $random(seed);
            model[reg_addr_t'(r)] = v;
            ws_to_rf.we   = 1'b1;
            ws_to_rf.addr = reg_addr_t'(r);
            ws_to_rf.data = v;
            @(posedge clk);
            #1;
        end
        ws_to_rf.we = 1'b0;
    endtask

    task automatic build_table();
        test_row_t r;
        word_t     ins;
        word_t     v4;
        fwd_src_t  none;
        fwd_src_t  z_exe;
        fwd_src_t  z_mem;
        fwd_src_t  z_wb;
        fwd_src_t  f_exe;
        fwd_src_t  f_mem;
        fwd_src_t  f_wb;
        none  = fwd_from(5'd0, 32'h0);
        z_exe = fwd_from(5'd0, EXE_RES);   // dest 0 with a live result
        z_mem = fwd_from(5'd0, MEM_RES);
        z_wb  = fwd_from(5'd0, WB_RES);
        f_exe = fwd_from(5'd1, EXE_RES);
        f_mem = fwd_from(5'd1, MEM_RES);
        f_wb  = fwd_from(5'd1, WB_RES);
        v4    = reg_val(5'd4);

        ins = rtype_inst(5'd1, 5'd2, 5'd3, 6'h21);   // addu r3, r1, r2
        r = '{1'b1, ins, 32'hbfc0_0100, none, none, none, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd3, ALU_ADD, IMM_SEL_REG,
              reg_val(5'd1), reg_val(5'd2), 1'b0, 1'b0, 32'h0, 1'b0, 5'd0};
        tbl.push_back(r);
        r = '{1'b1, ins, 32'hbfc0_0104, f_exe, f_mem, f_wb, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd3, ALU_ADD, IMM_SEL_REG,
              EXE_RES, reg_val(5'd2), 1'b0, 1'b0, 32'h0, 1'b0, 5'd0};
        tbl.push_back(r);
        r = '{1'b1, ins, 32'hbfc0_0108, z_exe, f_mem, f_wb, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd3, ALU_ADD, IMM_SEL_REG,
              MEM_RES, reg_val(5'd2), 1'b0, 1'b0, 32'h0, 1'b0, 5'd0};
        tbl.push_back(r);
        ins = rtype_inst(5'd0, 5'd2, 5'd3, 6'h21);   // rs is r0
        r = '{1'b1, ins, 32'hbfc0_010c, z_exe, z_mem, z_wb, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd3, ALU_ADD, IMM_SEL_REG,
              32'h0, reg_val(5'd2), 1'b0, 1'b0, 32'h0, 1'b0, 5'd0};
        tbl.push_back(r);

        // load-use on a taken beq, then the load moves on
        ins = itype_inst(6'h04, 5'd1, 5'd1, 16'h0010);
        r = '{1'b1, ins, 32'hbfc0_0200, f_exe, none, none, 1'b1, 1'b1, 1'b0,
              1'b0, 1'b0, 1'b0, 5'd0, ALU_NONE, IMM_SEL_REG, EXE_RES, EXE_RES,
              1'b1, 1'b1, cond_target(32'hbfc0_0200, 16'h0010), 1'b0, 5'd0};
        tbl.push_back(r);
        r = '{1'b0, 32'h0, 32'hbfc0_0200, f_exe, none, none, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd0, ALU_NONE, IMM_SEL_REG, EXE_RES, EXE_RES,
              1'b1, 1'b1, cond_target(32'hbfc0_0200, 16'h0010), 1'b0, 5'd0};
        tbl.push_back(r);

        ins = itype_inst(6'h05, 5'd1, 5'd2, 16'hfff0);   // bne jumping backwards
        r = '{1'b1, ins, 32'hbfc0_0300, none, none, none, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd0, ALU_NONE, IMM_SEL_REG, reg_val(5'd1), reg_val(5'd2),
              reg_val(5'd1) != reg_val(5'd2), 1'b1, cond_target(32'hbfc0_0300, 16'hfff0),
              1'b0, 5'd0};
        tbl.push_back(r);
        ins = itype_inst(6'h01, 5'd4, 5'd1, 16'h0040);   // bgez r4
        r = '{1'b1, ins, 32'hbfc0_0400, none, none, none, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd0, ALU_NONE, IMM_SEL_REG, v4, reg_val(5'd1),
              ~v4[31], 1'b1, cond_target(32'hbfc0_0400, 16'h0040), 1'b0, 5'd0};
        tbl.push_back(r);
        ins = itype_inst(6'h01, 5'd4, 5'd0, 16'h0040);   // bltz r4
        r = '{1'b1, ins, 32'hbfc0_0500, none, none, none, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd0, ALU_NONE, IMM_SEL_REG, v4, 32'h0,
              v4[31], 1'b1, cond_target(32'hbfc0_0500, 16'h0040), 1'b0, 5'd0};
        tbl.push_back(r);
        ins = jtype_inst(6'h02, 26'h0123456);
        r = '{1'b1, ins, 32'hbfc0_0600, none, none, none, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd0, ALU_NONE, IMM_SEL_REG, reg_val(ins[25:21]),
              reg_val(ins[20:16]), 1'b1, 1'b1, jump_target(32'hbfc0_0600, 26'h0123456),
              1'b0, 5'd0};
        tbl.push_back(r);
        ins = rtype_inst(5'd6, 5'd0, 5'd0, 6'h08);   // jr r6
        r = '{1'b1, ins, 32'hbfc0_0700, none, none, none, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd0, ALU_NONE, IMM_SEL_REG, reg_val(5'd6), 32'h0,
              1'b1, 1'b1, reg_val(5'd6), 1'b0, 5'd0};
        tbl.push_back(r);

        ins = itype_inst(6'h09, 5'd1, 5'd7, 16'h8001);   // addiu r7, r1
        r = '{1'b1, ins, 32'hbfc0_0800, none, none, none, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd7, ALU_ADD, IMM_SEL_SEXT,
              reg_val(5'd1), reg_val(5'd7), 1'b0, 1'b0, 32'h0, 1'b0, 5'd0};
        tbl.push_back(r);
        ins = itype_inst(6'h0d, 5'd1, 5'd8, 16'h00ff);   // ori r8, r1
        r = '{1'b1, ins, 32'hbfc0_0804, none, none, none, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd8, ALU_OR, IMM_SEL_ZEXT,
              reg_val(5'd1), reg_val(5'd8), 1'b0, 1'b0, 32'h0, 1'b0, 5'd0};
        tbl.push_back(r);
        ins = jtype_inst(6'h03, 26'h2a55aa4);   // jal links through r31
        r = '{1'b1, ins, 32'hbfc0_0808, none, none, none, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, reg_addr_t'(`ID_LINK_REG), ALU_ADD, IMM_SEL_REG,
              reg_val(ins[25:21]), reg_val(ins[20:16]), 1'b1, 1'b1,
              jump_target(32'hbfc0_0808, 26'h2a55aa4), 1'b0, 5'd0};
        tbl.push_back(r);

        r = '{1'b1, 32'hfc00_0000, 32'hbfc0_0900, none, none, none, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd0, ALU_NONE, IMM_SEL_REG, 32'h0, 32'h0,
              1'b0, 1'b0, 32'h0, 1'b1, exc_code_t'(`ID_EXC_RI)};
        tbl.push_back(r);
        ins = rtype_inst(5'd0, 5'd0, 5'd0, 6'h0c);   // syscall
        r = '{1'b1, ins, 32'hbfc0_0904, none, none, none, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd0, ALU_NONE, IMM_SEL_REG, 32'h0, 32'h0,
              1'b0, 1'b0, 32'h0, 1'b1, exc_code_t'(`ID_EXC_SYS)};
        tbl.push_back(r);
        ins = rtype_inst(5'd0, 5'd0, 5'd0, 6'h0d);   // break
        r = '{1'b1, ins, 32'hbfc0_0908, none, none, none, 1'b0, 1'b1, 1'b0,
              1'b1, 1'b1, 1'b0, 5'd0, ALU_NONE, IMM_SEL_REG, 32'h0, 32'h0,
              1'b0, 1'b0, 32'h0, 1'b1, exc_code_t'(`ID_EXC_BP)};
        tbl.push_back(r);

        // execute back-pressure holds the addu, then a flush drops it
        ins = rtype_inst(5'd1, 5'd2, 5'd3, 6'h21);
        r = '{1'b1, ins, 32'hbfc0_0a00, none, none, none, 1'b0, 1'b0, 1'b0,
              1'b1, 1'b0, 1'b0, 5'd3, ALU_ADD, IMM_SEL_REG,
              reg_val(5'd1), reg_val(5'd2), 1'b0, 1'b0, 32'h0, 1'b0, 5'd0};
        tbl.push_back(r);
        r.issue = 1'b0;
        tbl.push_back(r);
        r.flush       = 1'b1;
        r.exp_valid   = 1'b0;
        r.exp_allowin = 1'b1;
        r.only_valid  = 1'b1;
        tbl.push_back(r);
    endtask

    task automatic compare_value(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("FAIL t=%0t row %0d: %s is %h, expected %h",
                     $time, cur_row, what, got, exp);
            row_errs++;
        end
    endtask

    task automatic verify_row(input test_row_t r);
        compare_value("ds_to_es_valid", word_t'(ds_to_es_valid), word_t'(r.exp_valid));
        compare_value("ds_allowin", word_t'(ds_allowin), word_t'(r.exp_allowin));
        if (!r.only_valid) begin
            compare_value("dest", word_t'(ds_to_es_bus.ctrl.dest), word_t'(r.exp_dest));
            compare_value("gr_we", word_t'(ds_to_es_bus.ctrl.gr_we), word_t'(r.exp_dest != '0));
            compare_value("alu_op", word_t'(ds_to_es_bus.ctrl.alu_op), word_t'(r.exp_alu));
            compare_value("imm_sel", word_t'(ds_to_es_bus.ctrl.imm_sel), word_t'(r.exp_imm_sel));
            compare_value("rs_value", ds_to_es_bus.rs_value, r.exp_rs);
            compare_value("rt_value", ds_to_es_bus.rt_value, r.exp_rt);
            compare_value("pc", ds_to_es_bus.pc, r.pc);
            compare_value("is_branch", word_t'(br_bus.is_branch), word_t'(r.exp_branch));
            compare_value("br_taken", word_t'(br_bus.br_taken), word_t'(r.exp_taken));
            compare_value("br_stall", word_t'(br_bus.br_stall),
                          word_t'(r.exp_taken && !r.exp_valid));   // stalled rows only
            compare_value("ex", word_t'(ds_to_es_bus.ctrl.ex), word_t'(r.exp_ex));
            compare_value("exc_code", word_t'(ds_to_es_bus.ctrl.exc_code), word_t'(r.exp_code));
            if (r.exp_taken) begin
                compare_value("br_target", br_bus.br_target, r.exp_target);
            end
        end
    endtask

    // starts and ends 1 unit after a rising edge
    task automatic apply_row(input test_row_t r);
        int waited;
        row_errs   = 0;
        exe_fwd    = r.exe;
        mem_fwd    = r.mem;
        wb_fwd     = r.wb;
        es_load_op = r.load_op;
        es_allowin = r.allowin;
        if (r.issue) begin
            fs_to_ds_valid    = 1'b1;
            fs_to_ds_bus.inst = r.inst;
            fs_to_ds_bus.pc   = r.pc;
            waited = 0;
            #1;
            while (!ds_allowin && waited < 8) begin
                @(posedge clk);
                #2;
                waited++;
            end
            if (!ds_allowin) begin
                $display("row %0d: decode never accepted the instruction", cur_row);
                row_errs++;
            end
            @(posedge clk);
            #1;
            fs_to_ds_valid    = 1'b0;
            fs_to_ds_bus.inst = '0;
            fs_to_ds_bus.pc   = r.pc + 32'd4;   // delay slot now on the fetch bus
        end else if (r.flush) begin
            flush = 1'b1;
            @(posedge clk);
            #1;
            flush = 1'b0;
        end
        #1;
        verify_row(r);
        @(posedge clk);
        #1;
    endtask

    initial begin
        reset          = 1'b1;
        flush          = 1'b0;
        es_allowin     = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus   = '0;
        ws_to_rf       = '0;
        exe_fwd        = '0;
        mem_fwd        = '0;
        wb_fwd         = '0;
        es_load_op     = 1'b0;
        pass_count     = 0;
        fail_count     = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        preload_regs();
        build_table();
        for (int i = 0; i < tbl.size(); i++) begin
            cur_row = i;
            apply_row(tbl[i]);
            if (row_errs == 0) begin
                pass_count++;
                $display("row %0d ok", i);
            end else begin
                fail_count++;
                $display("row %0d: %0d mismatches", i, row_errs);
            end
        end
        $display("done: %0d rows, %0d ok, %0d with errors", tbl.size(), pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
